// ==== rtl/s16b_config.svh ====
`ifndef S16B_CONFIG_SVH
`define S16B_CONFIG_SVH

// Region indices, regions 0 to 2 are program ROM banks
`define S16B_REG_RAM   3
`define S16B_REG_ORAM  4
`define S16B_REG_VRAM  5
`define S16B_REG_PAL   6
`define S16B_REG_IO    7

// Address bits 23:16 of the mapper register window
`define S16B_MAPPER_PAGE 8'hFE

// Power-up memory map, base page and mask per region
`define S16B_RESET_BASE_0 8'h00
`define S16B_RESET_MASK_0 8'hFC
`define S16B_RESET_BASE_1 8'h04
`define S16B_RESET_MASK_1 8'hFC
`define S16B_RESET_BASE_2 8'h08
`define S16B_RESET_MASK_2 8'hFC
`define S16B_RESET_BASE_3 8'hFF
`define S16B_RESET_MASK_3 8'hFF
`define S16B_RESET_BASE_4 8'h44
`define S16B_RESET_MASK_4 8'hFF
`define S16B_RESET_BASE_5 8'h40
`define S16B_RESET_MASK_5 8'hFF
`define S16B_RESET_BASE_6 8'h84
`define S16B_RESET_MASK_6 8'hFF
`define S16B_RESET_BASE_7 8'hC4
`define S16B_RESET_MASK_7 8'hFF

// I/O sub-pages on address bits 13:12
`define S16B_IO_LATCH  2'd0
`define S16B_IO_INPUTS 2'd1
`define S16B_IO_DIPS   2'd2

`endif

// ==== rtl/s16b_pkg.sv ====
`default_nettype none

package s16b_pkg;

    // 68000 bus as driven by the CPU side
    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] dout;
        logic        rnw;
        logic        asn;
        logic        udsn;
        logic        ldsn;
    } cpu_bus_t;

    // Registered chip selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic objram;
        logic pal;
        logic io;
        logic tbank;
        logic mapper;
    } s16b_cs_t;

    // Cabinet inputs, all active low
    typedef struct packed {
        logic [7:0] joystick1;
        logic [7:0] joystick2;
        logic [1:0] start_button;
        logic [1:0] coin_input;
        logic       service;
        logic       dip_test;
    } cab_in_t;

    typedef enum logic [1:0] {
        GC_5797        = 2'd0,
        GC_5358_LARGE  = 2'd1,
        GC_5358_SMALL  = 2'd2,
        GC_5521_5704   = 2'd3
    } game_class_t;

    // Board class from the game identifier
    function automatic game_class_t game_class_of(input logic [7:0] game_id);
        game_class_t gc;
        casez (game_id[7:3])
            5'b001??: gc = GC_5797;
            5'b0001?: begin
                if (game_id == 8'h10 || game_id == 8'h1a)
                    gc = GC_5358_LARGE;
                else
                    gc = GC_5358_SMALL;
            end
            default:  gc = GC_5521_5704;
        endcase
        return gc;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/s16b_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16b_config.svh"

module s16b_mapper
    import s16b_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  cpu_bus_t        bus,
    output logic      [7:0] active,
    output logic      [7:0] map_dout
);

    // Even entries hold a region base, odd entries its mask
    localparam logic [7:0] RESET_MAP [16] = '{
        `S16B_RESET_BASE_0, `S16B_RESET_MASK_0,
        `S16B_RESET_BASE_1, `S16B_RESET_MASK_1,
        `S16B_RESET_BASE_2, `S16B_RESET_MASK_2,
        `S16B_RESET_BASE_3, `S16B_RESET_MASK_3,
        `S16B_RESET_BASE_4, `S16B_RESET_MASK_4,
        `S16B_RESET_BASE_5, `S16B_RESET_MASK_5,
        `S16B_RESET_BASE_6, `S16B_RESET_MASK_6,
        `S16B_RESET_BASE_7, `S16B_RESET_MASK_7
    };

    logic [7:0] map_regs [16];
    logic [7:0] page;
    logic [3:0] reg_idx;
    logic       win_hit;
    logic       win_wr;

    assign page    = bus.addr[23:16];
    assign reg_idx = bus.addr[4:1];
    assign win_hit = (page == `S16B_MAPPER_PAGE);

    // Only the low byte lane reaches the mapper registers
    assign win_wr  = win_hit && !bus.asn && !bus.rnw && !bus.ldsn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                map_regs[i] <= RESET_MAP[i];
            end
        end else if (win_wr) begin
            map_regs[reg_idx] <= bus.dout[7:0];
        end
    end

    assign map_dout = map_regs[reg_idx];

    // Scan from the top so the lowest matching region wins
    always_comb begin
        active = '0;
        for (int i = 7; i >= 0; i--) begin
            if ((page & map_regs[2*i+1]) == (map_regs[2*i] & map_regs[2*i+1])) begin
                active    = '0;
                active[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/s16b_chip_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16b_config.svh"

module s16b_chip_select
    import s16b_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  cpu_bus_t         bus,
    input  wire logic  [7:0] active,
    input  game_class_t      game_class,
    input  wire logic        rom_ok,
    input  wire logic        ram_ok,
    output s16b_cs_t         cs,
    output logic      [17:0] rom_addr,
    output logic       [5:0] tile_bank,
    output logic             dtack_n
);

    logic       ds_any;
    logic       busy;
    logic [1:0] act_enc;

    assign ds_any = !bus.udsn || !bus.ldsn;

    // Chip selects drop between cycles so every RAM request gets a new edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (!bus.asn) begin
            cs.rom    <= |active[2:0] && bus.rnw;
            cs.chr    <= active[`S16B_REG_VRAM] && bus.addr[16];
            cs.vram   <= active[`S16B_REG_VRAM] && !bus.addr[16] && ds_any;
            cs.ram    <= active[`S16B_REG_RAM] && ds_any;
            cs.objram <= active[`S16B_REG_ORAM];
            cs.pal    <= active[`S16B_REG_PAL];
            cs.io     <= active[`S16B_REG_IO];
            cs.tbank  <= active[2] && !bus.rnw;
            cs.mapper <= bus.addr[23:16] == `S16B_MAPPER_PAGE;
        end else begin
            cs <= '0;
        end
    end

    // Memory back-pressure holds DTACK off
    assign busy = (cs.rom && !rom_ok) || ((cs.ram || cs.vram) && !ram_ok);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dtack_n <= 1'b1;
        else
            dtack_n <= bus.asn || !(|cs) || busy;
    end

    always_comb begin
        case (active[2:0])
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    // Program ROM banking per board class
    always_comb begin
        case (game_class)
            GC_5797:       rom_addr = bus.addr[18:1];
            GC_5358_LARGE: rom_addr = {act_enc, bus.addr[16:1]};
            GC_5358_SMALL: rom_addr = {1'b0, act_enc, bus.addr[15:1]};
            default:       rom_addr = {act_enc[0], bus.addr[17:1]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (cs.tbank && !bus.ldsn) begin
            if (bus.addr[1])
                tile_bank[5:3] <= bus.dout[2:0];
            else
                tile_bank[2:0] <= bus.dout[2:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/s16b_cabinet.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16b_config.svh"

module s16b_cabinet
    import s16b_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  cpu_bus_t        bus,
    input  wire logic       io_cs,
    input  cab_in_t         cab,
    input  wire logic [7:0] dipsw_a,
    input  wire logic [7:0] dipsw_b,
    output logic      [7:0] cab_dout,
    output logic            flip,
    output logic            video_en
);

    logic [1:0] sub_page;
    logic [1:0] offset;
    logic [7:0] sys_inputs;

    assign sub_page = bus.addr[13:12];
    assign offset   = bus.addr[2:1];

    // Unused top bits float high like the board pull-ups
    assign sys_inputs = {2'b11, cab.service, cab.dip_test, cab.coin_input, cab.start_button};

    always_comb begin
        cab_dout = 8'hFF;
        case (sub_page)
            `S16B_IO_INPUTS: begin
                case (offset)
                    2'd0:    cab_dout = sys_inputs;
                    2'd1:    cab_dout = cab.joystick1;
                    2'd2:    cab_dout = cab.joystick2;
                    default: cab_dout = 8'hFF;
                endcase
            end
            `S16B_IO_DIPS:   cab_dout = bus.addr[1] ? dipsw_b : dipsw_a;
            default:         cab_dout = 8'hFF;
        endcase
    end

    // Flip and video enable latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b0;
        end else if (io_cs && !bus.rnw && !bus.ldsn && sub_page == `S16B_IO_LATCH) begin
            video_en <= bus.dout[5];
            flip     <= bus.dout[6];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/s16b_bus_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module s16b_bus_mux
    import s16b_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  s16b_cs_t         cs,
    input  wire logic [15:0] ram_data,
    input  wire logic [15:0] rom_data,
    input  wire logic [15:0] char_dout,
    input  wire logic [15:0] pal_dout,
    input  wire logic [15:0] obj_dout,
    input  wire logic  [7:0] cab_dout,
    input  wire logic  [7:0] map_dout,
    output logic      [15:0] cpu_din
);

    // Read source by priority, unmapped reads keep the last word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hFFFF;
        end else begin
            if (cs.ram || cs.vram)
                cpu_din <= ram_data;
            else if (cs.rom)
                cpu_din <= rom_data;
            else if (cs.chr)
                cpu_din <= char_dout;
            else if (cs.pal)
                cpu_din <= pal_dout;
            else if (cs.objram)
                cpu_din <= obj_dout;
            else if (cs.io)
                cpu_din <= {8'hFF, cab_dout};
            else if (cs.mapper)
                cpu_din <= {8'hFF, map_dout};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/s16b_main.sv ====
`timescale 1ns/1ps
`default_nettype none

module s16b_main
    import s16b_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  cpu_bus_t         bus,
    input  wire logic  [7:0] game_id,
    output s16b_cs_t         cs,
    output logic      [17:0] rom_addr,
    input  wire logic [15:0] rom_data,
    input  wire logic        rom_ok,
    input  wire logic [15:0] ram_data,
    input  wire logic        ram_ok,
    input  wire logic [15:0] char_dout,
    input  wire logic [15:0] pal_dout,
    input  wire logic [15:0] obj_dout,
    input  cab_in_t          cab,
    input  wire logic  [7:0] dipsw_a,
    input  wire logic  [7:0] dipsw_b,
    output logic      [15:0] cpu_din,
    output logic             dtack_n,
    output logic       [5:0] tile_bank,
    output logic             flip,
    output logic             video_en
);

    logic [7:0]  active;
    logic [7:0]  map_dout;
    logic [7:0]  cab_dout;
    game_class_t game_class;

    assign game_class = game_class_of(game_id);

    s16b_mapper u_mapper (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .active   (active),
        .map_dout (map_dout)
    );

    s16b_chip_select u_cs (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus),
        .active     (active),
        .game_class (game_class),
        .rom_ok     (rom_ok),
        .ram_ok     (ram_ok),
        .cs         (cs),
        .rom_addr   (rom_addr),
        .tile_bank  (tile_bank),
        .dtack_n    (dtack_n)
    );

    s16b_cabinet u_cabinet (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .io_cs    (cs.io),
        .cab      (cab),
        .dipsw_a  (dipsw_a),
        .dipsw_b  (dipsw_b),
        .cab_dout (cab_dout),
        .flip     (flip),
        .video_en (video_en)
    );

    s16b_bus_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .cs        (cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .map_dout  (map_dout),
        .cpu_din   (cpu_din)
    );

endmodule

`default_nettype wire

// ==== sim/s16b_main_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module s16b_main_checker
    import s16b_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  cpu_bus_t  bus,
    input  s16b_cs_t  cs,
    input  wire logic rom_ok,
    input  wire logic dtack_n
);

    // Assertion failure count
    int unsigned fail_count = 0;

    logic [6:0] mem_sel;

    assign mem_sel = {cs.rom, cs.ram, cs.vram, cs.chr, cs.objram, cs.pal, cs.io};

    // Region decode is one-hot, so one memory select at most
    one_mem_select: assert property (@(posedge clk) disable iff (rst) $onehot0(mem_sel))
        else begin
            $error("more than one memory chip select is active");
            fail_count++;
        end

    // Selects drop once the address strobe has gone high
    selects_clear: assert property (@(posedge clk) disable iff (rst) bus.asn |=> (cs == '0))
        else begin
            $error("chip selects still active after the address strobe rose");
            fail_count++;
        end

    // ROM wait holds DTACK off
    rom_wait_dtack: assert property (@(posedge clk) disable iff (rst)
        (cs.rom && !rom_ok) |-> dtack_n)
        else begin
            $error("DTACK asserted while the ROM was not ready");
            fail_count++;
        end

endmodule

bind s16b_main s16b_main_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus),
    .cs      (cs),
    .rom_ok  (rom_ok),
    .dtack_n (dtack_n)
);

`default_nettype wire

// ==== sim/s16b_main_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16b_config.svh"

module s16b_main_tb
    import s16b_pkg::*;
();

    typedef enum logic [2:0] {K_RD, K_WR, K_ROM, K_UNMAP, K_TILE, K_LATCH} kind_t;

    // One bus cycle, ds is {udsn, ldsn}
    typedef struct packed {
        kind_t       kind;
        logic [7:0]  gid;
        logic [23:0] addr;
        logic [15:0] wdata;
        logic [1:0]  ds;
        logic [15:0] want;
    } step_t;

    localparam int NSTEPS = 39;
    localparam step_t STEPS [NSTEPS] = '{
        '{K_UNMAP, 8'h20, 24'h200000, 16'h0000, 2'b00, 16'hFFFF},
        '{K_RD,    8'h20, 24'h440010, 16'h0000, 2'b00, 16'h0D5F},
        '{K_RD,    8'h20, 24'h840020, 16'h0000, 2'b00, 16'h7B1E},
        '{K_UNMAP, 8'h20, 24'h900000, 16'h0000, 2'b00, 16'h7B1E},
        '{K_ROM,   8'h20, 24'h012346, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h20, 24'h05A0B2, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h10, 24'h0A7F10, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h10, 24'h012346, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h12, 24'h05A0B2, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h12, 24'h0A7F10, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h40, 24'h05A0B2, 16'h0000, 2'b00, 16'h0000},
        '{K_ROM,   8'h40, 24'h0A7F10, 16'h0000, 2'b00, 16'h0000},
        '{K_WR,    8'h20, 24'hFF0000, 16'h1111, 2'b00, 16'h0000},
        '{K_WR,    8'h20, 24'hFF0002, 16'h5566, 2'b00, 16'h0000},
        '{K_WR,    8'h20, 24'hFF0002, 16'hABCD, 2'b10, 16'h0000},
        '{K_WR,    8'h20, 24'h400004, 16'h9E3F, 2'b00, 16'h0000},
        '{K_RD,    8'h20, 24'hFF0000, 16'h0000, 2'b00, 16'h1111},
        '{K_RD,    8'h20, 24'hFF0002, 16'h0000, 2'b00, 16'h55CD},
        '{K_RD,    8'h20, 24'h400004, 16'h0000, 2'b00, 16'h9E3F},
        '{K_RD,    8'h20, 24'hC41000, 16'h0000, 2'b00, 16'hFFE6},
        '{K_RD,    8'h20, 24'hC41002, 16'h0000, 2'b00, 16'hFFE7},
        '{K_RD,    8'h20, 24'hC41004, 16'h0000, 2'b00, 16'hFFBD},
        '{K_RD,    8'h20, 24'hC41006, 16'h0000, 2'b00, 16'hFFFF},
        '{K_RD,    8'h20, 24'hC42000, 16'h0000, 2'b00, 16'hFF3C},
        '{K_RD,    8'h20, 24'hC42002, 16'h0000, 2'b00, 16'hFFD2},
        '{K_RD,    8'h20, 24'hC43000, 16'h0000, 2'b00, 16'hFFFF},
        '{K_LATCH, 8'h20, 24'hC40000, 16'h0060, 2'b00, 16'h0003},
        '{K_LATCH, 8'h20, 24'hC40000, 16'h0020, 2'b00, 16'h0001},
        '{K_TILE,  8'h20, 24'h080002, 16'h0005, 2'b00, 16'h0028},
        '{K_TILE,  8'h20, 24'h080000, 16'h0003, 2'b00, 16'h002B},
        // RAM base moves to page A0, VRAM mask opens page 41 for char reads
        '{K_WR,    8'h20, {`S16B_MAPPER_PAGE, 16'h000C}, 16'h00A0, 2'b00, 16'h0000},
        '{K_WR,    8'h20, {`S16B_MAPPER_PAGE, 16'h0016}, 16'h00FE, 2'b00, 16'h0000},
        '{K_RD,    8'h20, {`S16B_MAPPER_PAGE, 16'h000C}, 16'h0000, 2'b00, 16'hFFA0},
        '{K_RD,    8'h20, {`S16B_MAPPER_PAGE, 16'h0016}, 16'h0000, 2'b00, 16'hFFFE},
        '{K_WR,    8'h20, 24'hA00010, 16'h1234, 2'b00, 16'h0000},
        '{K_RD,    8'h20, 24'hA00010, 16'h0000, 2'b00, 16'h1234},
        '{K_UNMAP, 8'h20, 24'hFF0010, 16'h0000, 2'b00, 16'h1234},
        '{K_RD,    8'h20, 24'h410000, 16'h0000, 2'b00, 16'hC4A7},
        '{K_RD,    8'h20, 24'h400004, 16'h0000, 2'b00, 16'h9E3F}
    };

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    bus;
    logic [7:0]  game_id;
    s16b_cs_t    cs;
    logic [17:0] rom_addr;
    logic [15:0] rom_data;
    logic        rom_ok = 1'b0;
    logic [15:0] ram_data;
    logic        ram_ok = 1'b0;
    cab_in_t     cab;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic [5:0]  tile_bank;
    logic        flip;
    logic        video_en;

    logic [15:0] ram_mem [4096];
    logic [11:0] ram_idx;
    int unsigned rom_wait = 0;
    int unsigned ram_wait = 0;
    int          errors = 0;
    int          step_no = 0;
    int unsigned chk_fails;

    always #4 clk = ~clk;

    assign cab = '{joystick1: 8'hE7, joystick2: 8'hBD, start_button: 2'b10,
                   coin_input: 2'b01, service: 1'b1, dip_test: 1'b0};

    s16b_main dut0 (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .game_id   (game_id),
        .cs        (cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (16'hC4A7),
        .pal_dout  (16'h7B1E),
        .obj_dout  (16'h0D5F),
        .cab       (cab),
        .dipsw_a   (8'h3C),
        .dipsw_b   (8'hD2),
        .cpu_din   (cpu_din),
        .dtack_n   (dtack_n),
        .tile_bank (tile_bank),
        .flip      (flip),
        .video_en  (video_en)
    );

    // ROM contents spread over the whole word address
    function automatic logic [15:0] rom_word(input logic [17:0] a);
        return a[15:0] ^ {a[17:16], a[17:16], 12'h000} ^ 16'h5A3C;
    endfunction

    // Bank is the region index, pages 00 to 0B in the reset map
    function automatic logic [17:0] banked_rom_addr(input game_class_t gc,
                                                    input logic [23:0] a);
        logic [1:0] bank;
        bank = a[19:18];
        case (gc)
            GC_5797:       return a[18:1];
            GC_5358_LARGE: return {bank, a[16:1]};
            GC_5358_SMALL: return {1'b0, bank, a[15:1]};
            default:       return {bank[0], a[17:1]};
        endcase
    endfunction

    assign rom_data = rom_word(rom_addr);
    assign ram_idx  = {cs.vram, bus.addr[11:1]};
    assign ram_data = ram_mem[ram_idx];

    always @(posedge clk) begin
        if ((cs.ram || cs.vram) && ram_ok && !bus.rnw) begin
            if (!bus.udsn)
                ram_mem[ram_idx][15:8] <= bus.dout[15:8];
            if (!bus.ldsn)
                ram_mem[ram_idx][7:0] <= bus.dout[7:0];
        end
    end

    // Memories answer 0 to 3 cycles after their select
    always @(negedge clk) begin
        if (!cs.rom) begin
            rom_ok   <= 1'b0;
            rom_wait <= $urandom % 4;
        end else if (rom_wait == 0) begin
            rom_ok <= 1'b1;
        end else begin
            rom_wait <= rom_wait - 1;
        end
    end

    always @(negedge clk) begin
        if (!(cs.ram || cs.vram)) begin
            ram_ok   <= 1'b0;
            ram_wait <= $urandom % 4;
        end else if (ram_wait == 0) begin
            ram_ok <= 1'b1;
        end else begin
            ram_wait <= ram_wait - 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("FAIL step %0d %s: got %0h, expected %0h", step_no, name, got, want);
            errors++;
        end
    endtask

    task automatic run_bus_cycle(input step_t s);
        int          waited;
        logic        write;
        logic [17:0] want_addr;
        waited    = 0;
        write     = (s.kind == K_WR || s.kind == K_TILE || s.kind == K_LATCH);
        want_addr = banked_rom_addr(game_class_of(s.gid), s.addr);
        @(negedge clk);
        game_id  = s.gid;
        bus.addr = s.addr[23:1];
        bus.dout = s.wdata;
        bus.rnw  = !write;
        bus.udsn = s.ds[1];
        bus.ldsn = s.ds[0];
        bus.asn  = 1'b0;
        if (s.kind == K_UNMAP) begin
            // Nothing decodes here, DTACK stays off and the data holds
            repeat (4) begin
                @(negedge clk);
                assert (dtack_n) else begin
                    $display("Step %0d: DTACK came back for an unmapped page", step_no);
                    errors++;
                end
            end
            check_value("cpu_din", 32'(cpu_din), 32'(s.want));
        end else begin
            while (dtack_n && waited < 16) begin
                @(negedge clk);
                waited++;
            end
            assert (!dtack_n) else begin
                $display("Step %0d: no DTACK within 16 cycles", step_no);
                errors++;
            end
            case (s.kind)
                K_RD: check_value("cpu_din", 32'(cpu_din), 32'(s.want));
                K_ROM: begin
                    check_value("rom_addr", 32'(rom_addr), 32'(want_addr));
                    check_value("cpu_din", 32'(cpu_din), 32'(rom_word(want_addr)));
                end
                K_TILE: check_value("tile_bank", 32'(tile_bank), 32'(s.want[5:0]));
                K_LATCH: begin
                    check_value("flip", 32'(flip), 32'(s.want[1]));
                    check_value("video_en", 32'(video_en), 32'(s.want[0]));
                end
                default: ;
            endcase
        end
        bus.asn  = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        bus.rnw  = 1'b1;
    endtask

    // Watchdog sized from the table length
    initial begin
        #((NSTEPS * 20 + 16) * 8);
        $display("Watchdog expired before the bus cycles finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(70923));
        // RAM starts with a pattern over the whole index
        for (int i = 0; i < 4096; i++) begin
            ram_mem[i] = 16'(i) ^ 16'hC35A;
        end
        rst     = 1'b1;
        game_id = 8'h20;
        bus     = '{addr: '0, dout: '0, rnw: 1'b1, asn: 1'b1, udsn: 1'b1, ldsn: 1'b1};
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("cs", {23'h0, cs}, 32'h0);
        check_value("dtack_n", 32'(dtack_n), 32'h1);
        check_value("cpu_din", 32'(cpu_din), 32'hFFFF);
        check_value("tile_bank", 32'(tile_bank), 32'h0);
        check_value("flip", 32'(flip), 32'h0);
        check_value("video_en", 32'(video_en), 32'h0);
        rst = 1'b0;
        for (int i = 0; i < NSTEPS; i++) begin
            step_no = i + 1;
            run_bus_cycle(STEPS[i]);
        end
        repeat (2) @(negedge clk);
        chk_fails = dut0.u_checker.fail_count;
        $display("Errors: %0d testbench checks, %0d bus assertions", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/s16b_pkg.sv
rtl/s16b_mapper.sv
rtl/s16b_chip_select.sv
rtl/s16b_cabinet.sv
rtl/s16b_bus_mux.sv
rtl/s16b_main.sv
sim/s16b_main_checker.sv
sim/s16b_main_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the System 16B bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module s16b_main_tb \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vs16b_main_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
